/* rp_analog_top.f */
verilog/rp_pkg.sv
verilog/rp_linear.sv
verilog/rp_calib_regs.sv
verilog/rp_adc_path.sv
verilog/rp_dac_path.sv
verilog/rp_analog_top.sv
sim/rp_analog_asserts.sv
sim/rp_analog_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rp_analog_tb -f rp_analog_top.f \
  --Mdir obj_dir -o rp_analog_sim

./obj_dir/rp_analog_sim 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* sim/rp_analog_asserts.sv */
`timescale 1ns/1ps

module rp_analog_asserts (
  input logic                                        adc_clk,
  input logic                                        top_rst,
  input logic [rp_pkg::CHN_N-1:0][rp_pkg::SMP_W-1:0] adc_dat_o,
  input logic [rp_pkg::CHN_N-1:0]                    adc_vld_o,
  input logic [rp_pkg::CHN_N-1:0]                    adc_rdy_i,
  input logic                                        dac_wrt_o
);

  import rp_pkg::*;

  // stalled ADC stream keeps its data
  for (genvar i = 0; i < CHN_N; i++) begin : g_stall
    assert property (@(posedge adc_clk) disable iff (top_rst)
      (adc_vld_o[i] && !adc_rdy_i[i]) |=> $stable(adc_dat_o[i]))
      else $error("adc channel %0d data changed while stalled", i);
  end : g_stall

  // outputs quiet right after reset
  assert property (@(posedge adc_clk) top_rst |=> (adc_vld_o == '0 && !dac_wrt_o))
    else $error("stream valid or dac write high after reset");

  // write strobe always known once out of reset
  assert property (@(posedge adc_clk) disable iff (top_rst) !$isunknown(dac_wrt_o))
    else $error("dac write strobe unknown");

endmodule : rp_analog_asserts

bind rp_analog_top rp_analog_asserts asserts (.*);

/* sim/rp_analog_tb.sv */
`timescale 1ns/1ps

module rp_analog_tb;

  import rp_pkg::*;

  logic                         adc_clk = 1'b0;
  logic                         top_rst;
  logic                         cfg_wen_i;
  logic [ADDR_W-1:0]            cfg_addr_i;
  logic [REG_W-1:0]             cfg_wdat_i;
  logic [REG_W-1:0]             cfg_rdat_o;
  logic [CHN_N-1:0][SMP_W-1:0]  adc_dat_i;
  smp_t [CHN_N-1:0]             adc_dat_o;
  logic [CHN_N-1:0]             adc_vld_o;
  logic [CHN_N-1:0]             adc_rdy_i;
  smp_t [CHN_N-1:0]             gen_dat_i;
  logic [CHN_N-1:0]             gen_vld_i;
  logic [CHN_N-1:0]             gen_rdy_o;
  dac_code_t [CHN_N-1:0]        dac_dat_o;
  logic                         dac_wrt_o;

  // bookkeeping
  int        errors = 0;
  int        tests_run = 0;
  int        tests_failed = 0;
  // stream capture
  bit        adc_mon = 1'b0;
  bit        dac_mon = 1'b0;
  int        pulse_cnt = 0;
  smp_t      got_q[CHN_N][$];
  dac_code_t exp_code[CHN_N][$];
  // calibration as written to the DUT
  mul_t      adc_g[CHN_N];
  smp_t      adc_o[CHN_N];
  mul_t      dac_g[CHN_N];
  smp_t      dac_o[CHN_N];

  rp_analog_top DUT (.*);

  always #2 adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // product, floor shift, offset, clamp
  function automatic smp_t lin_model(input smp_t s, input mul_t g, input smp_t o);
    longint p;
    p = longint'(s) * longint'(g);
    p = (p >>> 14) + longint'(o);
    if (p > 8191) return smp_t'(8191);
    if (p < -8192) return smp_t'(-8192);
    return smp_t'(p);
  endfunction

  // offset binary to two's complement
  function automatic smp_t adc_conv(input logic [SMP_W-1:0] r);
    return smp_t'({r[13], ~r[12:0]});
  endfunction

  function automatic dac_code_t dac_conv(input smp_t s);
    return {s[13], ~s[12:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // compare
  ////////////////////////////////////////////////////////////

  task automatic check_smp(input smp_t got, input smp_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_code(input dac_code_t got, input dac_code_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got 0x%h expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s read 0x%h expected 0x%h", $time, what, got, exp);
    end
  endtask

  // stream content that fits no expected sequence
  task automatic mismatch_error(input string msg);
    errors++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s at %0t ns", msg, $time);
  endtask

  // stream capture at the falling edge, values settled
  always @(negedge adc_clk) begin
    for (int ch = 0; ch < CHN_N; ch++) begin
      if (adc_mon && adc_vld_o[ch] && adc_rdy_i[ch]) got_q[ch].push_back(adc_dat_o[ch]);
    end
    if (dac_mon && dac_wrt_o) begin
      pulse_cnt++;
      for (int ch = 0; ch < CHN_N; ch++) begin
        if (exp_code[ch].size() == 0) begin
          report_failure($sformatf("dac write on channel %0d with no pending sample", ch));
        end else begin
          check_code(dac_dat_o[ch], exp_code[ch].pop_front(), $sformatf("dac ch%0d", ch));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // bus and stream helpers
  ////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [REG_W-1:0] d);
    @(posedge adc_clk);
    cfg_wen_i  <= 1'b1;
    cfg_addr_i <= a;
    cfg_wdat_i <= d;
    @(posedge adc_clk);
    cfg_wen_i  <= 1'b0;
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] a, output logic [REG_W-1:0] d);
    @(posedge adc_clk);
    cfg_addr_i <= a;
    @(posedge adc_clk);
    @(negedge adc_clk);
    d = cfg_rdat_o;
  endtask

  task automatic apply_cal();
    for (int ch = 0; ch < CHN_N; ch++) begin
      write_reg(4'(int'(ADC_MUL0) + ch), 16'(adc_g[ch]));
      write_reg(4'(int'(ADC_SUM0) + ch), 16'(adc_o[ch]));
      write_reg(4'(int'(DAC_MUL0) + ch), 16'(dac_g[ch]));
      write_reg(4'(int'(DAC_SUM0) + ch), 16'(dac_o[ch]));
    end
    // let older samples leave the pipelines
    repeat (6) @(posedge adc_clk);
  endtask

  // one generator channel, random idle gaps
  task automatic drive_gen(input int ch, input smp_t vals[$]);
    int t;
    for (int i = 0; i < vals.size(); i++) begin
      repeat ($urandom_range(0, 4)) @(posedge adc_clk);
      @(posedge adc_clk);
      gen_dat_i[ch] <= vals[i];
      gen_vld_i[ch] <= 1'b1;
      t = 0;
      do begin
        @(negedge adc_clk);
        t++;
      end while (!gen_rdy_o[ch] && t < 200);
      if (!gen_rdy_o[ch]) report_failure($sformatf("timeout: generator ch%0d never ready", ch));
      @(posedge adc_clk);
      gen_vld_i[ch] <= 1'b0;
    end
  endtask

  task automatic wait_pulses(input int n);
    int t;
    t = 0;
    while (pulse_cnt < n && t < 400) begin
      @(negedge adc_clk);
      t++;
    end
    if (pulse_cnt < n) report_failure("timeout: dac write pulses missing");
  endtask

  // offers codes on both ADC channels, bp adds random stalls
  task automatic run_adc(input int n, input bit bp);
    logic [SMP_W-1:0] seq[CHN_N][$];
    logic [SMP_W-1:0] offered[CHN_N][$];
    logic [SMP_W-1:0] code;
    int span;
    int k;
    int idx;
    bit rdy_on;
    bit ok;
    bit found;
    span = 0;
    rdy_on = 1'b1;
    for (int ch = 0; ch < CHN_N; ch++) begin
      got_q[ch].delete();
      // samples still in flight carry the held code
      for (k = 0; k < 5; k++) offered[ch].push_back(adc_dat_i[ch]);
    end
    adc_mon = 1'b1;
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      for (int ch = 0; ch < CHN_N; ch++) begin
        code = 14'($urandom);
        // full scale both ways
        if (i % 8 == 0) code = '0;
        else if (i % 8 == 1) code = '1;
        adc_dat_i[ch] <= code;
        seq[ch].push_back(code);
        offered[ch].push_back(code);
      end
      if (bp) begin
        if (span == 0) begin
          rdy_on = !rdy_on;
          span = $urandom_range(1, 6);
        end
        span--;
        adc_rdy_i <= {CHN_N{rdy_on}};
      end
    end
    // drain with the last code held
    for (int t = 0; t < 10; t++) begin
      @(posedge adc_clk);
      adc_rdy_i <= '1;
      for (int ch = 0; ch < CHN_N; ch++) offered[ch].push_back(seq[ch][n-1]);
    end
    @(negedge adc_clk);
    adc_mon = 1'b0;
    for (int ch = 0; ch < CHN_N; ch++) begin
      if (!bp) begin
        // whole sequence must appear back to back
        found = 1'b0;
        for (int s = 0; s + n <= got_q[ch].size() && !found; s++) begin
          ok = 1'b1;
          for (int j = 0; j < n; j++) begin
            if (got_q[ch][s+j] !== lin_model(adc_conv(seq[ch][j]), adc_g[ch], adc_o[ch]))
              ok = 1'b0;
          end
          found = ok;
        end
        if (!found) mismatch_error($sformatf("adc ch%0d output does not follow the input", ch));
      end else begin
        if (got_q[ch].size() == 0) report_failure($sformatf("adc ch%0d moved no sample", ch));
        // each output maps to a later offered code
        idx = -1;
        for (int m = 0; m < got_q[ch].size(); m++) begin
          k = idx + 1;
          while (k < offered[ch].size() &&
                 lin_model(adc_conv(offered[ch][k]), adc_g[ch], adc_o[ch]) !== got_q[ch][m])
            k++;
          if (k == offered[ch].size()) begin
            mismatch_error($sformatf("adc ch%0d output %0d matches no later code", ch, m));
            break;
          end
          idx = k;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_regs();
    logic [REG_W-1:0] d;
    logic [REG_W-1:0] w;
    logic [REG_W-1:0] exp;
    for (int a = 0; a < 9; a++) begin
      read_reg(4'(a), d);
      exp = (a < 2 || a == 4 || a == 5) ? 16'h4000 : 16'h0000;
      check_reg(d, exp, $sformatf("reset value addr %0d", a));
    end
    for (int a = 0; a < 9; a++) begin
      w = 16'($urandom);
      case (reg_addr_e'(a))
        ADC_SUM0, ADC_SUM1, DAC_SUM0, DAC_SUM1: begin
          // even offsets negative, odd positive
          w[13] = (a % 2 == 0);
          exp = {{2{w[13]}}, w[13:0]};
        end
        MUX_LOOP: exp = {14'b0, w[1:0]};
        default:  exp = w;
      endcase
      write_reg(4'(a), w);
      read_reg(4'(a), d);
      check_reg(d, exp, $sformatf("readback addr %0d", a));
    end
    write_reg(4'd11, 16'hffff);
    read_reg(4'd11, d);
    check_reg(d, 16'h0000, "unused addr 11");
    write_reg(MUX_LOOP, 16'h0000);
    for (int ch = 0; ch < CHN_N; ch++) begin
      adc_g[ch] = MUL_UNITY;
      dac_g[ch] = MUL_UNITY;
      adc_o[ch] = '0;
      dac_o[ch] = '0;
    end
    apply_cal();
  endtask

  task automatic test_adc_cal();
    adc_g[0] = mul_t'(16'h7fff);
    adc_g[1] = mul_t'(16'h8000);
    adc_o[0] = smp_t'($urandom_range(0, 300));
    adc_o[1] = -smp_t'($urandom_range(0, 300));
    apply_cal();
    run_adc(48, 1'b0);
    for (int ch = 0; ch < CHN_N; ch++) begin
      adc_g[ch] = mul_t'($urandom);
      adc_o[ch] = smp_t'($urandom);
    end
    apply_cal();
    run_adc(48, 1'b0);
  endtask

  task automatic test_dac(input int n);
    smp_t v0[$];
    smp_t v1[$];
    for (int ch = 0; ch < CHN_N; ch++) begin
      dac_g[ch] = mul_t'($urandom_range(0, 32767));
      dac_o[ch] = smp_t'($urandom_range(0, 1000)) - smp_t'(500);
    end
    apply_cal();
    for (int i = 0; i < n; i++) begin
      v0.push_back(smp_t'($urandom));
      v1.push_back(smp_t'($urandom));
      exp_code[0].push_back(dac_conv(lin_model(v0[i], dac_g[0], dac_o[0])));
      exp_code[1].push_back(dac_conv(lin_model(v1[i], dac_g[1], dac_o[1])));
    end
    pulse_cnt = 0;
    dac_mon = 1'b1;
    fork
      drive_gen(0, v0);
      drive_gen(1, v1);
    join
    wait_pulses(n);
    repeat (10) @(negedge adc_clk);
    dac_mon = 1'b0;
    if (pulse_cnt != n) report_failure($sformatf("%0d dac writes for %0d pairs", pulse_cnt, n));
  endtask

  task automatic test_loop();
    smp_t v0[$];
    smp_t v1[$];
    smp_t dac_smp;
    @(posedge adc_clk);
    adc_dat_i[1] <= 14'($urandom);
    write_reg(MUX_LOOP, 16'h0001);
    v0.push_back(smp_t'($urandom));
    v1.push_back(smp_t'($urandom));
    dac_smp = lin_model(v0[0], dac_g[0], dac_o[0]);
    exp_code[0].push_back(dac_conv(dac_smp));
    exp_code[1].push_back(dac_conv(lin_model(v1[0], dac_g[1], dac_o[1])));
    pulse_cnt = 0;
    dac_mon = 1'b1;
    fork
      drive_gen(0, v0);
      drive_gen(1, v1);
    join
    wait_pulses(1);
    dac_mon = 1'b0;
    // loopback sample through ADC calibration
    repeat (6) @(negedge adc_clk);
    if (adc_vld_o !== 2'b11) report_failure("adc streams not valid during loopback");
    check_smp(adc_dat_o[0], lin_model(dac_smp, adc_g[0], adc_o[0]), "loopback ch0");
    check_smp(adc_dat_o[1], lin_model(adc_conv(adc_dat_i[1]), adc_g[1], adc_o[1]),
              "direct ch1");
    write_reg(MUX_LOOP, 16'h0000);
  endtask

  task automatic close_test(input string name, input int err0);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err0);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  initial begin
    int e;
    void'($urandom(32'hdd82));
    top_rst    = 1'b1;
    cfg_wen_i  = 1'b0;
    cfg_addr_i = '0;
    cfg_wdat_i = '0;
    adc_dat_i  = '0;
    adc_rdy_i  = '1;
    gen_dat_i  = '0;
    gen_vld_i  = '0;
    repeat (2) @(posedge adc_clk);
    top_rst <= 1'b0;
    repeat (3) @(posedge adc_clk);

    e = errors;
    test_regs();
    close_test("register reset and readback", e);
    e = errors;
    run_adc(64, 1'b0);
    close_test("adc unity gain", e);
    e = errors;
    test_adc_cal();
    close_test("adc calibration and saturation", e);
    e = errors;
    run_adc(96, 1'b1);
    close_test("adc back-pressure", e);
    e = errors;
    test_dac(12);
    close_test("dac pair join", e);
    e = errors;
    test_loop();
    close_test("digital loopback", e);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : rp_analog_tb

/* verilog/rp_adc_path.sv */
`timescale 1ns/1ps

module rp_adc_path (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  // raw converter code, offset binary
  input  logic [rp_pkg::SMP_W-1:0] adc_dat_i,
  // loopback
  input  logic                     loop_i,
  input  rp_pkg::smp_t             loop_smp_i,
  // calibration
  input  rp_pkg::mul_t             mul_i,
  input  rp_pkg::smp_t             sum_i,
  // calibrated stream
  output rp_pkg::smp_t             dat_o,
  output logic                     vld_o,
  input  logic                     rdy_i
);

  import rp_pkg::*;

  smp_t raw_q;
  logic raw_vld;
  smp_t lin_dat;

  ////////////////////////////////////////////////////////////
  // input register
  ////////////////////////////////////////////////////////////

  // free running, the converter has no handshake
  always_ff @(posedge adc_clk) begin
    raw_q <= smp_t'(flip_code(adc_dat_i));
  end

  // first raw sample is ready one edge after reset release
  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      raw_vld <= 1'b0;
    end else begin
      raw_vld <= 1'b1;
    end
  end

  // digital loopback multiplexer
  assign lin_dat = loop_i ? loop_smp_i : raw_q;

  // ready left open, samples refused by linear are dropped
  rp_linear lin (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .mul_i     (mul_i),
    .sum_i     (sum_i),
    .in_dat_i  (lin_dat),
    .in_vld_i  (raw_vld),
    .in_rdy_o  (),
    .out_dat_o (dat_o),
    .out_vld_o (vld_o),
    .out_rdy_i (rdy_i)
  );

endmodule : rp_adc_path

/* verilog/rp_analog_top.sv */
`timescale 1ns/1ps

module rp_analog_top (
  input  logic                                        adc_clk,
  input  logic                                        top_rst,
  // configuration
  input  logic                                        cfg_wen_i,
  input  logic [rp_pkg::ADDR_W-1:0]                   cfg_addr_i,
  input  logic [rp_pkg::REG_W-1:0]                    cfg_wdat_i,
  output logic [rp_pkg::REG_W-1:0]                    cfg_rdat_o,
  // ADC
  input  logic [rp_pkg::CHN_N-1:0][rp_pkg::SMP_W-1:0] adc_dat_i,
  output rp_pkg::smp_t [rp_pkg::CHN_N-1:0]            adc_dat_o,
  output logic [rp_pkg::CHN_N-1:0]                    adc_vld_o,
  input  logic [rp_pkg::CHN_N-1:0]                    adc_rdy_i,
  // generator
  input  rp_pkg::smp_t [rp_pkg::CHN_N-1:0]            gen_dat_i,
  input  logic [rp_pkg::CHN_N-1:0]                    gen_vld_i,
  output logic [rp_pkg::CHN_N-1:0]                    gen_rdy_o,
  // DAC
  output rp_pkg::dac_code_t [rp_pkg::CHN_N-1:0]       dac_dat_o,
  output logic                                        dac_wrt_o
);

  import rp_pkg::*;

  logic             rst_q;
  // calibration
  mul_t [CHN_N-1:0] adc_mul;
  smp_t [CHN_N-1:0] adc_sum;
  mul_t [CHN_N-1:0] dac_mul;
  smp_t [CHN_N-1:0] dac_sum;
  logic [CHN_N-1:0] mux_loop;
  // last DAC pair, signed
  smp_t [CHN_N-1:0] loop_smp;

  ////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////

  // asserts at once, releases on the next clock edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rst_q <= 1'b1;
    end else begin
      rst_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // calibration registers
  ////////////////////////////////////////////////////////////

  rp_calib_regs regs (
    .adc_clk   (adc_clk),
    .rst_i     (rst_q),
    .wen_i     (cfg_wen_i),
    .addr_i    (cfg_addr_i),
    .wdat_i    (cfg_wdat_i),
    .rdat_o    (cfg_rdat_o),
    .adc_mul_o (adc_mul),
    .adc_sum_o (adc_sum),
    .dac_mul_o (dac_mul),
    .dac_sum_o (dac_sum),
    .loop_o    (mux_loop)
  );

  ////////////////////////////////////////////////////////////
  // ADC IO
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CHN_N; i++) begin : g_adc
    rp_adc_path adc (
      .adc_clk    (adc_clk),
      .rst_i      (rst_q),
      .adc_dat_i  (adc_dat_i[i]),
      .loop_i     (mux_loop[i]),
      .loop_smp_i (loop_smp[i]),
      .mul_i      (adc_mul[i]),
      .sum_i      (adc_sum[i]),
      .dat_o      (adc_dat_o[i]),
      .vld_o      (adc_vld_o[i]),
      .rdy_i      (adc_rdy_i[i])
    );
  end : g_adc

  ////////////////////////////////////////////////////////////
  // DAC IO
  ////////////////////////////////////////////////////////////

  rp_dac_path dac (
    .adc_clk    (adc_clk),
    .rst_i      (rst_q),
    .gen_dat_i  (gen_dat_i),
    .gen_vld_i  (gen_vld_i),
    .gen_rdy_o  (gen_rdy_o),
    .mul_i      (dac_mul),
    .sum_i      (dac_sum),
    .dac_dat_o  (dac_dat_o),
    .dac_wrt_o  (dac_wrt_o),
    .loop_smp_o (loop_smp)
  );

endmodule : rp_analog_top

/* verilog/rp_calib_regs.sv */
`timescale 1ns/1ps

module rp_calib_regs (
  input  logic                                 adc_clk,
  input  logic                                 rst_i,
  // register port
  input  logic                                 wen_i,
  input  logic [rp_pkg::ADDR_W-1:0]            addr_i,
  input  logic [rp_pkg::REG_W-1:0]             wdat_i,
  output logic [rp_pkg::REG_W-1:0]             rdat_o,
  // acquire calibration
  output rp_pkg::mul_t [rp_pkg::CHN_N-1:0]     adc_mul_o,
  output rp_pkg::smp_t [rp_pkg::CHN_N-1:0]     adc_sum_o,
  // generate calibration
  output rp_pkg::mul_t [rp_pkg::CHN_N-1:0]     dac_mul_o,
  output rp_pkg::smp_t [rp_pkg::CHN_N-1:0]     dac_sum_o,
  // loopback select, one bit per channel
  output logic [rp_pkg::CHN_N-1:0]             loop_o
);

  import rp_pkg::*;

  reg_addr_e        addr;
  logic [REG_W-1:0] rd_dat;

  // out of map addresses fall into the default branches
  assign addr = reg_addr_e'(addr_i);

  ////////////////////////////////////////////////////////////
  // write
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      adc_mul_o <= {CHN_N{MUL_UNITY}};
      adc_sum_o <= {CHN_N{SUM_ZERO}};
      dac_mul_o <= {CHN_N{MUL_UNITY}};
      dac_sum_o <= {CHN_N{SUM_ZERO}};
      loop_o    <= '0;
    end else if (wen_i) begin
      case (addr)
        ADC_MUL0: adc_mul_o[0] <= mul_t'(wdat_i);
        ADC_MUL1: adc_mul_o[1] <= mul_t'(wdat_i);
        // offsets take the low bits only
        ADC_SUM0: adc_sum_o[0] <= smp_t'(wdat_i[SMP_W-1:0]);
        ADC_SUM1: adc_sum_o[1] <= smp_t'(wdat_i[SMP_W-1:0]);
        DAC_MUL0: dac_mul_o[0] <= mul_t'(wdat_i);
        DAC_MUL1: dac_mul_o[1] <= mul_t'(wdat_i);
        DAC_SUM0: dac_sum_o[0] <= smp_t'(wdat_i[SMP_W-1:0]);
        DAC_SUM1: dac_sum_o[1] <= smp_t'(wdat_i[SMP_W-1:0]);
        MUX_LOOP: loop_o       <= wdat_i[CHN_N-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read
  ////////////////////////////////////////////////////////////

  // offsets sign extended, loop bits zero extended
  always_comb begin
    case (addr)
      ADC_MUL0: rd_dat = REG_W'(adc_mul_o[0]);
      ADC_MUL1: rd_dat = REG_W'(adc_mul_o[1]);
      ADC_SUM0: rd_dat = REG_W'(adc_sum_o[0]);
      ADC_SUM1: rd_dat = REG_W'(adc_sum_o[1]);
      DAC_MUL0: rd_dat = REG_W'(dac_mul_o[0]);
      DAC_MUL1: rd_dat = REG_W'(dac_mul_o[1]);
      DAC_SUM0: rd_dat = REG_W'(dac_sum_o[0]);
      DAC_SUM1: rd_dat = REG_W'(dac_sum_o[1]);
      MUX_LOOP: rd_dat = REG_W'(loop_o);
      default:  rd_dat = '0;
    endcase
  end

  // one edge of read latency
  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      rdat_o <= '0;
    end else begin
      rdat_o <= rd_dat;
    end
  end

endmodule : rp_calib_regs

/* verilog/rp_dac_path.sv */
`timescale 1ns/1ps

module rp_dac_path (
  input  logic                                 adc_clk,
  input  logic                                 rst_i,
  // generator streams
  input  rp_pkg::smp_t [rp_pkg::CHN_N-1:0]     gen_dat_i,
  input  logic [rp_pkg::CHN_N-1:0]             gen_vld_i,
  output logic [rp_pkg::CHN_N-1:0]             gen_rdy_o,
  // calibration
  input  rp_pkg::mul_t [rp_pkg::CHN_N-1:0]     mul_i,
  input  rp_pkg::smp_t [rp_pkg::CHN_N-1:0]     sum_i,
  // DAC
  output rp_pkg::dac_code_t [rp_pkg::CHN_N-1:0] dac_dat_o,
  output logic                                 dac_wrt_o,
  // signed copy for the loopback
  output rp_pkg::smp_t [rp_pkg::CHN_N-1:0]     loop_smp_o
);

  import rp_pkg::*;

  smp_t [CHN_N-1:0] lin_dat;
  logic [CHN_N-1:0] lin_vld;
  // both channels leave linear together
  logic             pair_go;

  ////////////////////////////////////////////////////////////
  // per channel calibration
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CHN_N; i++) begin : g_lin
    rp_linear lin (
      .adc_clk   (adc_clk),
      .rst_i     (rst_i),
      .mul_i     (mul_i[i]),
      .sum_i     (sum_i[i]),
      .in_dat_i  (gen_dat_i[i]),
      .in_vld_i  (gen_vld_i[i]),
      .in_rdy_o  (gen_rdy_o[i]),
      .out_dat_o (lin_dat[i]),
      .out_vld_o (lin_vld[i]),
      .out_rdy_i (pair_go)
    );
  end : g_lin

  ////////////////////////////////////////////////////////////
  // pair join and output registers
  ////////////////////////////////////////////////////////////

  // a channel running ahead holds in its own pipeline
  assign pair_go = &lin_vld;

  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      dac_dat_o  <= {CHN_N{DAC_ZERO}};
      loop_smp_o <= {CHN_N{SUM_ZERO}};
      dac_wrt_o  <= 1'b0;
    end else begin
      // single cycle write strobe
      dac_wrt_o <= pair_go;
      if (pair_go) begin
        for (int i = 0; i < CHN_N; i++) begin
          dac_dat_o[i]  <= dac_code_t'(flip_code(lin_dat[i]));
          loop_smp_o[i] <= lin_dat[i];
        end
      end
    end
  end

endmodule : rp_dac_path

/* verilog/rp_linear.sv */
`timescale 1ns/1ps

module rp_linear (
  input  logic         adc_clk,
  input  logic         rst_i,
  // calibration
  input  rp_pkg::mul_t mul_i,
  input  rp_pkg::smp_t sum_i,
  // input stream
  input  rp_pkg::smp_t in_dat_i,
  input  logic         in_vld_i,
  output logic         in_rdy_o,
  // output stream
  output rp_pkg::smp_t out_dat_o,
  output logic         out_vld_o,
  input  logic         out_rdy_i
);

  import rp_pkg::*;

  // stage one, full product
  logic s1_vld;
  prd_t s1_prd;
  logic s1_en;
  // stage two, shifted, offset and clamped
  logic s2_vld;
  smp_t s2_dat;
  logic s2_en;
  // shift plus offset before clamping
  acc_t acc;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // a stage moves when empty or when its content leaves this edge
  assign s2_en = ~s2_vld | out_rdy_i;
  assign s1_en = ~s1_vld | s2_en;

  // stalls only with both stages full and a blocked output
  assign in_rdy_o = s1_en;

  ////////////////////////////////////////////////////////////
  // stage one
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      s1_vld <= 1'b0;
    end else if (s1_en) begin
      s1_vld <= in_vld_i;
    end
  end

  // both operands widened first so the product keeps every bit
  always_ff @(posedge adc_clk) begin
    if (s1_en) begin
      s1_prd <= prd_t'(in_dat_i) * prd_t'(mul_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // stage two
  ////////////////////////////////////////////////////////////

  // arithmetic shift rounds toward minus infinity
  // shifted product fits MUL_W bits, guard bit absorbs the offset
  assign acc = acc_t'(s1_prd >>> MUL_SHIFT) + acc_t'(sum_i);

  always_ff @(posedge adc_clk, posedge rst_i) begin
    if (rst_i) begin
      s2_vld <= 1'b0;
    end else if (s2_en) begin
      s2_vld <= s1_vld;
    end
  end

  // saturate to the sample range
  always_ff @(posedge adc_clk) begin
    if (s2_en) begin
      if (acc > SMP_MAX) begin
        s2_dat <= SMP_MAX;
      end else if (acc < SMP_MIN) begin
        s2_dat <= SMP_MIN;
      end else begin
        s2_dat <= smp_t'(acc);
      end
    end
  end

  assign out_dat_o = s2_dat;
  assign out_vld_o = s2_vld;

endmodule : rp_linear

/* verilog/rp_pkg.sv */
package rp_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // number of analog channels, acquire and generate
  localparam int CHN_N = 2;
  // converter sample width
  localparam int SMP_W = 14;
  // calibration gain, 2.14 fixed point
  localparam int MUL_W = 16;
  localparam int MUL_SHIFT = 14;
  // full product, then shifted product plus offset with one guard bit
  localparam int PRD_W = SMP_W + MUL_W;
  localparam int ACC_W = PRD_W - MUL_SHIFT + 1;
  // configuration bus
  localparam int REG_W = 16;
  localparam int ADDR_W = 4;

  ////////////////////////////////////////////////////////////
  // sample types
  ////////////////////////////////////////////////////////////

  // signed sample, also used for offsets
  typedef logic signed [SMP_W-1:0] smp_t;
  typedef logic signed [MUL_W-1:0] mul_t;
  typedef logic signed [PRD_W-1:0] prd_t;
  typedef logic signed [ACC_W-1:0] acc_t;
  // raw code toward the DAC pins
  typedef logic [SMP_W-1:0] dac_code_t;

  // reset values
  localparam mul_t MUL_UNITY = mul_t'(16384);
  localparam smp_t SUM_ZERO = '0;
  // code for a zero sample
  localparam dac_code_t DAC_ZERO = {1'b0, {(SMP_W-1){1'b1}}};

  // saturation limits
  localparam smp_t SMP_MAX = smp_t'(2**(SMP_W-1) - 1);
  localparam smp_t SMP_MIN = smp_t'(-(2**(SMP_W-1)));

  // register map
  typedef enum logic [ADDR_W-1:0] {
    ADC_MUL0 = 0,
    ADC_MUL1 = 1,
    ADC_SUM0 = 2,
    ADC_SUM1 = 3,
    DAC_MUL0 = 4,
    DAC_MUL1 = 5,
    DAC_SUM0 = 6,
    DAC_SUM1 = 7,
    MUX_LOOP = 8
  } reg_addr_e;

  // msb kept, lower bits inverted
  // same mapping in both directions, so ADC and DAC share it
  function automatic logic [SMP_W-1:0] flip_code(input logic [SMP_W-1:0] val);
    return {val[SMP_W-1], ~val[SMP_W-2:0]};
  endfunction

endpackage : rp_pkg
